// File: sim.f
+incdir+src
src/exec_pkg.sv
src/forward_if.sv
src/exec_alu.sv
src/branch_compare.sv
src/exec_stage.sv
src/forward_unit.sv
src/retire_stage.sv
src/exec_top.sv
bench/exec_assertions.sv
bench/exec_tb.sv

// File: Makefile
# Verilator build, run and lint for the execute block
OBJ = obj_dir

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module exec_tb -Mdir $(OBJ)
	./$(OBJ)/Vexec_tb +verilator+error+limit+1000 | tee sim.log
	@grep -qx "Simulation passed" sim.log

lint:
	verilator --lint-only --timing --assert -Wall -f sim.f --top-module exec_tb

clean:
	rm -rf $(OBJ) sim.log

// File: bench/exec_tb.sv
//////////////////////////////////////////////////
// Testbench for the execute and retire pipeline
// Random micro-ops through ALU, branch, CSR,
// bypass and stall or flush phases, checked
// against a cycle model of the handshake rules
//////////////////////////////////////////////////

`timescale 1ns/1ps

module exec_tb
    import exec_pkg::*;
();

    // Expected retire beat
    typedef struct packed {
        word_t    pc;
        reg_idx_t rd_idx;
        logic     rd_we;
        word_t    rd_val;
        word_t    csr_new_val;
        logic     branch_taken;
        logic     check_target;
        word_t    branch_target;
    } expect_s;

    logic     clk;
    logic     rst_n;
    logic     stall;
    logic     flush;
    logic     in_valid;
    uop_s     stim;
    logic     out_valid;
    word_t    out_pc;
    reg_idx_t out_rd_idx;
    logic     out_rd_we;
    word_t    out_rd_val;
    word_t    out_csr_new_val;
    logic     out_branch_taken;
    word_t    out_branch_target;

    expect_s  exp_q[$];
    string    name_q[$];
    string    test_name;
    // Model of the execute input register and the retire slot
    logic     m_valid;
    uop_s     m_uop;
    logic     prev_fire;
    logic     prev_rd_we;
    reg_idx_t prev_rd_idx;
    word_t    prev_rd_val;
    word_t    pc_next;
    reg_idx_t last_rd;
    uop_s     u;
    int       checks;
    int       mismatches;
    int       other_errors;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    exec_top dut0 (
        .clk (clk), .rst_n (rst_n), .stall (stall), .flush (flush), .in_valid (in_valid),
        .in_pc (stim.pc), .in_rs1_idx (stim.rs1_idx), .in_rs2_idx (stim.rs2_idx),
        .in_rs1_val (stim.rs1_val), .in_rs2_val (stim.rs2_val),
        .in_immediate (stim.immediate), .in_rd_idx (stim.rd_idx), .in_rd_we (stim.rd_we),
        .in_rd_src (stim.rd_src), .in_alu_op (stim.alu_op), .in_op1_src (stim.op1_src),
        .in_op2_src (stim.op2_src), .in_cmp_op (stim.cmp_op),
        .in_branch_type (stim.branch_type), .in_csr_src (stim.csr_src),
        .in_csr_op (stim.csr_op), .in_csr_zimm (stim.csr_zimm),
        .in_csr_old_val (stim.csr_old_val),
        .out_valid (out_valid), .out_pc (out_pc), .out_rd_idx (out_rd_idx),
        .out_rd_we (out_rd_we), .out_rd_val (out_rd_val),
        .out_csr_new_val (out_csr_new_val), .out_branch_taken (out_branch_taken),
        .out_branch_target (out_branch_target)
    );

    // Signed compare from the sign bits
    function automatic logic less_signed(word_t a, word_t b);
        if (a[31] != b[31]) begin
            return a[31];
        end
        return a < b;
    endfunction

    function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_SLL:  return a << b[4:0];
            ALU_SLT:  return {31'd0, less_signed(a, b)};
            ALU_SLTU: return {31'd0, a < b};
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            // Sign fill of the vacated upper bits
            ALU_SRA:  return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
            ALU_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic ref_cmp(cmp_op_e op, word_t a, word_t b);
        case (op)
            CMP_EQ:  return a == b;
            CMP_NE:  return a != b;
            CMP_LT:  return less_signed(a, b);
            CMP_GE:  return !less_signed(a, b);
            CMP_LTU: return a < b;
            default: return !(a < b);
        endcase
    endfunction

    // Expected beat, with bypass from the previous retiring op
    function automatic expect_s predict(uop_s op, logic fwd_ok, reg_idx_t f_idx, word_t f_val);
        word_t   r1;
        word_t   r2;
        word_t   a;
        word_t   b;
        word_t   csr_opnd;
        expect_s e;
        fwd_ok = fwd_ok && (f_idx != '0);
        r1 = (fwd_ok && f_idx == op.rs1_idx) ? f_val : op.rs1_val;
        r2 = (fwd_ok && f_idx == op.rs2_idx) ? f_val : op.rs2_val;
        a = (op.op1_src == OP1_RS1) ? r1 : (op.op1_src == OP1_PC) ? op.pc :
            (op.op1_src == OP1_CSR) ? op.csr_old_val : 32'd0;
        b = (op.op2_src == OP2_RS1) ? r1 : (op.op2_src == OP2_RS2) ? r2 :
            (op.op2_src == OP2_IMM) ? op.immediate : 32'd4;
        e.pc     = op.pc;
        e.rd_idx = op.rd_idx;
        e.rd_we  = op.rd_we;
        // CSR ops write rd with the old CSR value
        e.rd_val = (op.rd_src == RD_SRC_CSR) ? op.csr_old_val : ref_alu(op.alu_op, a, b);
        csr_opnd = (op.csr_src == CSR_SRC_ZIMM) ? {27'd0, op.csr_zimm} : r1;
        e.csr_new_val = (op.csr_op == CSR_SET) ? (op.csr_old_val | csr_opnd) :
                        (op.csr_op == CSR_CLEAR) ? (op.csr_old_val & ~csr_opnd) : csr_opnd;
        e.branch_taken  = (op.branch_type == BRANCH_COND) ? ref_cmp(op.cmp_op, r1, r2) :
                          (op.branch_type != BRANCH_NONE);
        e.check_target  = (op.branch_type != BRANCH_NONE);
        e.branch_target = (op.branch_type == BRANCH_JALR) ? r1 + op.immediate
                                                          : op.pc + op.immediate;
        return e;
    endfunction

    // One clock of the handshake model, on the values of the cycle just ended
    task automatic model_step();
        logic fire;
        if (!rst_n) begin
            m_valid   = 1'b0;
            prev_fire = 1'b0;
        end else begin
            fire = m_valid && !stall && !flush;
            if (fire) begin
                exp_q.push_back(predict(m_uop, prev_fire && prev_rd_we, prev_rd_idx,
                                        prev_rd_val));
                name_q.push_back(test_name);
                prev_rd_we  = m_uop.rd_we;
                prev_rd_idx = m_uop.rd_idx;
                prev_rd_val = exp_q[$].rd_val;
            end
            prev_fire = fire;
            if (!stall) begin
                m_valid = in_valid;
                m_uop   = stim;
            end
        end
    endtask

    task automatic tick(logic v, uop_s op, logic st, logic fl);
        @(posedge clk);
        model_step();
        in_valid <= v;
        stim     <= op;
        stall    <= st;
        flush    <= fl;
    endtask

    // Present one op until a cycle without stall takes it
    task automatic send(uop_s op, int stall_pct, int flush_pct);
        int   tries;
        logic st;
        logic fl;
        tries = 0;
        do begin
            st = ($urandom_range(99, 0) < stall_pct);
            fl = !st && ($urandom_range(99, 0) < flush_pct);
            tick(1'b1, op, st, fl);
            tries++;
        end while (st && tries < 50);
        if (st) begin
            $display("Timeout: micro-op at pc %h was never accepted", op.pc);
            other_errors++;
        end
    endtask

    // Idle until every expected beat has retired
    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || m_valid) && waited < 100) begin
            tick(1'b0, stim, 1'b0, 1'b0);
            waited++;
        end
        if (waited >= 100) begin
            $display("Timeout: %0d expected results in %s never retired", exp_q.size(),
                     test_name);
            other_errors++;
        end
        tick(1'b0, stim, 1'b0, 1'b0);
    endtask

    function automatic uop_s rand_uop();
        uop_s op;
        op.pc          = pc_next;
        op.rs1_idx     = 5'($urandom);
        op.rs2_idx     = 5'($urandom);
        op.rs1_val     = $urandom;
        op.rs2_val     = $urandom;
        op.immediate   = $urandom;
        op.rd_idx      = 5'($urandom);
        op.rd_we       = 1'($urandom);
        op.rd_src      = RD_SRC_ALU;
        op.alu_op      = alu_op_e'(4'($urandom_range(9, 0)));
        op.op1_src     = op1_src_e'(2'($urandom));
        op.op2_src     = op2_src_e'(2'($urandom));
        op.cmp_op      = cmp_op_e'(3'($urandom_range(5, 0)));
        op.branch_type = BRANCH_NONE;
        op.csr_src     = csr_src_e'(1'($urandom));
        op.csr_op      = csr_op_e'(2'($urandom_range(2, 0)));
        op.csr_zimm    = 5'($urandom);
        op.csr_old_val = $urandom;
        return op;
    endfunction

    task automatic check_word(string name, string field, word_t exp, word_t act);
        checks++;
        assert (act === exp) else begin
            $display("Mismatch %s %s expected %h actual %h", name, field, exp, act);
            mismatches++;
        end
    endtask

    task automatic compare(expect_s e, string name);
        check_word(name, "pc", e.pc, out_pc);
        check_word(name, "rd_idx", word_t'(e.rd_idx), word_t'(out_rd_idx));
        check_word(name, "rd_we", word_t'(e.rd_we), word_t'(out_rd_we));
        check_word(name, "rd_val", e.rd_val, out_rd_val);
        check_word(name, "csr_new_val", e.csr_new_val, out_csr_new_val);
        check_word(name, "branch_taken", word_t'(e.branch_taken), word_t'(out_branch_taken));
        if (e.check_target) begin
            check_word(name, "branch_target", e.branch_target, out_branch_target);
        end
    endtask

    // Outputs sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (out_valid == 1'b0) else begin
                $display("Error: out_valid is high during reset");
                other_errors++;
            end
        end else if (out_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("Error: out_valid is high with no accepted micro-op pending");
                other_errors++;
            end
            if (exp_q.size() != 0) begin
                compare(exp_q.pop_front(), name_q.pop_front());
            end
        end
    end

    initial begin
        void'($urandom(32'h543c));
        checks = 0;
        mismatches = 0;
        other_errors = 0;
        rst_n = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        in_valid = 1'b0;
        stim = '0;
        m_valid = 1'b0;
        m_uop = '0;
        prev_fire = 1'b0;
        prev_rd_we = 1'b0;
        prev_rd_idx = '0;
        prev_rd_val = '0;
        pc_next = 32'h0000_1000;
        last_rd = '0;
        test_name = "reset";
        repeat (10) tick(1'b0, stim, 1'b0, 1'b0);
        rst_n <= 1'b1;
        repeat (3) tick(1'b0, stim, 1'b0, 1'b0);

        test_name = "alu";
        repeat (80) begin
            u = rand_uop();
            pc_next += 4;
            send(u, 0, 0);
        end
        drain();

        // Equal operands half the time so EQ and GE get taken
        test_name = "branch";
        repeat (80) begin
            u = rand_uop();
            pc_next += 4;
            u.branch_type = branch_e'(2'($urandom));
            if ($urandom_range(1, 0) == 1) begin
                u.rs2_val = u.rs1_val;
            end
            send(u, 0, 0);
        end
        drain();

        test_name = "csr";
        repeat (60) begin
            u = rand_uop();
            pc_next += 4;
            u.rd_src = RD_SRC_CSR;
            send(u, 0, 0);
        end
        drain();

        // Dependent chains, with x0 as destination now and then
        test_name = "forward";
        repeat (80) begin
            u = rand_uop();
            pc_next += 4;
            u.rd_we   = 1'b1;
            u.op1_src = OP1_RS1;
            u.op2_src = OP2_RS2;
            u.branch_type = branch_e'(2'($urandom));
            if ($urandom_range(3, 0) == 0) begin
                u.rd_idx = '0;
            end
            case ($urandom_range(2, 0))
                0: u.rs1_idx = last_rd;
                1: u.rs2_idx = last_rd;
                default: begin
                    u.rs1_idx = last_rd;
                    u.rs2_idx = last_rd;
                end
            endcase
            last_rd = u.rd_idx;
            send(u, 0, 0);
        end
        drain();

        test_name = "stall_flush";
        repeat (120) begin
            u = rand_uop();
            pc_next += 4;
            u.rd_src = rd_src_e'(1'($urandom));
            u.branch_type = branch_e'(2'($urandom));
            if ($urandom_range(1, 0) == 1) begin
                u.rs1_idx = last_rd;
            end
            last_rd = u.rd_idx;
            send(u, 30, 10);
        end
        drain();

        $display("Checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 checks, mismatches, other_errors, dut0.chk0.fail_count);
        if (mismatches == 0 && other_errors == 0 && dut0.chk0.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: bench/exec_assertions.sv
//////////////////////////////////////////////////
// Protocol checks bound into the execute top
// Watches the hazard controls and the two cycle
// latency from acceptance to retire
//////////////////////////////////////////////////

`timescale 1ns/1ps

module exec_assertions (
    input logic clk,
    input logic rst_n,
    input logic stall,
    input logic flush,
    input logic in_valid,
    input logic out_valid
);

    // Failures seen so far, read by the testbench at the end
    int fail_count = 0;

    // Retire valid always driven once out of reset
    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid))
        else begin
            $error("out_valid is unknown after reset");
            fail_count++;
        end

    // Hazard controls are exclusive
    a_no_stall_flush: assert property (@(posedge clk) disable iff (!rst_n)
        !(stall && flush))
        else begin
            $error("stall and flush are high in the same cycle");
            fail_count++;
        end

    // Accepted op with a clean execute cycle retires two cycles later
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !stall) ##1 (!stall && !flush) |=> out_valid)
        else begin
            $error("accepted micro-op did not retire two cycles later");
            fail_count++;
        end

    // Pipeline comes out of reset empty
    a_reset_empty: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
        else begin
            $error("out_valid high in the first cycle after reset");
            fail_count++;
        end

endmodule

bind exec_top exec_assertions chk0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .flush     (flush),
    .in_valid  (in_valid),
    .out_valid (out_valid)
);

// File: src/exec_top.sv
//////////////////////////////////////////////////
// Top of the execute and retire pipeline
// Takes each micro-op field as its own port and
// links execute, retire and the bypass network
//////////////////////////////////////////////////

`timescale 1ns/1ps

module exec_top
    import exec_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    input  logic       flush,
    input  logic       in_valid,
    input  word_t      in_pc,
    input  reg_idx_t   in_rs1_idx,
    input  reg_idx_t   in_rs2_idx,
    input  word_t      in_rs1_val,
    input  word_t      in_rs2_val,
    input  word_t      in_immediate,
    input  reg_idx_t   in_rd_idx,
    input  logic       in_rd_we,
    input  rd_src_e    in_rd_src,
    input  alu_op_e    in_alu_op,
    input  op1_src_e   in_op1_src,
    input  op2_src_e   in_op2_src,
    input  cmp_op_e    in_cmp_op,
    input  branch_e    in_branch_type,
    input  csr_src_e   in_csr_src,
    input  csr_op_e    in_csr_op,
    input  logic [4:0] in_csr_zimm,
    input  word_t      in_csr_old_val,
    output logic       out_valid,
    output word_t      out_pc,
    output reg_idx_t   out_rd_idx,
    output logic       out_rd_we,
    output word_t      out_rd_val,
    output word_t      out_csr_new_val,
    output logic       out_branch_taken,
    output word_t      out_branch_target
);

    uop_s     in_uop;
    logic     ex_valid;
    result_s  ex_result;
    logic     ret_valid;
    result_s  ret_result;
    logic     ret_rd_we;
    reg_idx_t ret_rd_idx;
    word_t    ret_rd_val;

    // One bypass channel per source operand
    forward_if fwd_rs1_if ();
    forward_if fwd_rs2_if ();

    // Pack the field ports into a micro-op
    always_comb begin
        in_uop.pc          = in_pc;
        in_uop.rs1_idx     = in_rs1_idx;
        in_uop.rs2_idx     = in_rs2_idx;
        in_uop.rs1_val     = in_rs1_val;
        in_uop.rs2_val     = in_rs2_val;
        in_uop.immediate   = in_immediate;
        in_uop.rd_idx      = in_rd_idx;
        in_uop.rd_we       = in_rd_we;
        in_uop.rd_src      = in_rd_src;
        in_uop.alu_op      = in_alu_op;
        in_uop.op1_src     = in_op1_src;
        in_uop.op2_src     = in_op2_src;
        in_uop.cmp_op      = in_cmp_op;
        in_uop.branch_type = in_branch_type;
        in_uop.csr_src     = in_csr_src;
        in_uop.csr_op      = in_csr_op;
        in_uop.csr_zimm    = in_csr_zimm;
        in_uop.csr_old_val = in_csr_old_val;
    end

    exec_stage exec0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .fwd_rs1   (fwd_rs1_if.stage),
        .fwd_rs2   (fwd_rs2_if.stage),
        .stall     (stall),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_uop    (in_uop),
        .ex_valid  (ex_valid),
        .ex_result (ex_result)
    );

    forward_unit fwd0 (
        .fwd_rs1    (fwd_rs1_if.fwd),
        .fwd_rs2    (fwd_rs2_if.fwd),
        .ret_valid  (ret_valid),
        .ret_rd_we  (ret_rd_we),
        .ret_rd_idx (ret_rd_idx),
        .ret_rd_val (ret_rd_val)
    );

    retire_stage retire0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_valid   (ex_valid),
        .ex_result  (ex_result),
        .ret_valid  (ret_valid),
        .ret_result (ret_result),
        .ret_rd_we  (ret_rd_we),
        .ret_rd_idx (ret_rd_idx),
        .ret_rd_val (ret_rd_val)
    );

    // Retired result to the outside
    assign out_valid         = ret_valid;
    assign out_pc            = ret_result.pc;
    assign out_rd_idx        = ret_rd_idx;
    assign out_rd_we         = ret_rd_we;
    assign out_rd_val        = ret_rd_val;
    assign out_csr_new_val   = ret_result.csr_new_val;
    assign out_branch_taken  = ret_result.branch_taken;
    assign out_branch_target = ret_result.branch_target;

endmodule

// File: src/retire_stage.sv
//////////////////////////////////////////////////
// Retire stage after execute
// Registers the execute result, picks the value
// written to rd and offers it for bypassing
//////////////////////////////////////////////////

`timescale 1ns/1ps

module retire_stage
    import exec_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ex_valid,
    input  result_s  ex_result,
    output logic     ret_valid,
    output result_s  ret_result,
    output logic     ret_rd_we,
    output reg_idx_t ret_rd_idx,
    output word_t    ret_rd_val
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= ex_valid;
        end
    end

    // Payload only moves with a valid result
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            ret_result <= ex_result;
        end
    end

    assign ret_rd_we  = ret_result.rd_we;
    assign ret_rd_idx = ret_result.rd_idx;

    // CSR ops write rd with the old CSR value
    assign ret_rd_val = (ret_result.rd_src == RD_SRC_CSR) ? ret_result.csr_old_val
                                                          : ret_result.alu_result;

endmodule

// File: src/forward_unit.sv
//////////////////////////////////////////////////
// Bypass network from retire back into execute
// Matches each execute source against the retire
// destination and returns the retiring value
//////////////////////////////////////////////////

`timescale 1ns/1ps

module forward_unit
    import exec_pkg::*;
(
    forward_if.fwd fwd_rs1,
    forward_if.fwd fwd_rs2,
    input  logic     ret_valid,
    input  logic     ret_rd_we,
    input  reg_idx_t ret_rd_idx,
    input  word_t    ret_rd_val
);

    // Retire holds a live, writing, nonzero destination
    logic ret_src_ok;

    // x0 is hardwired to zero, never a bypass source
    assign ret_src_ok = ret_valid && ret_rd_we && (ret_rd_idx != '0);

    // rs1 match
    assign fwd_rs1.use_fwd = ret_src_ok && fwd_rs1.stage_uses_reg
                             && (fwd_rs1.reg_idx == ret_rd_idx);

    // rs2 match
    assign fwd_rs2.use_fwd = ret_src_ok && fwd_rs2.stage_uses_reg
                             && (fwd_rs2.reg_idx == ret_rd_idx);

    // One writeback value feeds both operands
    assign fwd_rs1.fwd_val = ret_rd_val;
    assign fwd_rs2.fwd_val = ret_rd_val;

endmodule

// File: src/exec_stage.sv
//////////////////////////////////////////////////
// Execute stage of the in-order pipeline
// Holds one micro-op, resolves operands through
// the bypass path, and produces ALU, branch and
// CSR results for retire in the same cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

module exec_stage
    import exec_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    forward_if.stage fwd_rs1,
    forward_if.stage fwd_rs2,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    input  uop_s     in_uop,
    output logic     ex_valid,
    output result_s  ex_result
);

    logic  uop_valid;
    uop_s  uop;
    word_t rs1_val;
    word_t rs2_val;
    word_t operand_a;
    word_t operand_b;
    word_t alu_result;
    logic  cmp_result;
    logic  branch_taken;
    word_t branch_target;
    word_t csr_operand;
    word_t csr_new_val;

    // Input register, frozen while stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            uop_valid <= 1'b0;
        end else if (!stall) begin
            uop_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            uop <= in_uop;
        end
    end

    // Bypass requests for both sources
    assign fwd_rs1.stage_uses_reg = uop_valid;
    assign fwd_rs2.stage_uses_reg = uop_valid;
    assign fwd_rs1.reg_idx        = uop.rs1_idx;
    assign fwd_rs2.reg_idx        = uop.rs2_idx;

    // Forwarded value wins over the decoded one
    assign rs1_val = fwd_rs1.use_fwd ? fwd_rs1.fwd_val : uop.rs1_val;
    assign rs2_val = fwd_rs2.use_fwd ? fwd_rs2.fwd_val : uop.rs2_val;

    // ALU operand muxes
    always_comb begin
        case (uop.op1_src)
            OP1_RS1: operand_a = rs1_val;
            OP1_PC:  operand_a = uop.pc;
            OP1_CSR: operand_a = uop.csr_old_val;
            default: operand_a = '0;
        endcase
        case (uop.op2_src)
            OP2_RS1: operand_b = rs1_val;
            OP2_RS2: operand_b = rs2_val;
            OP2_IMM: operand_b = uop.immediate;
            default: operand_b = word_t'(4);
        endcase
    end

    exec_alu alu0 (
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .alu_op     (uop.alu_op),
        .alu_result (alu_result)
    );

    branch_compare cmp0 (
        .lhs        (rs1_val),
        .rhs        (rs2_val),
        .cmp_op     (uop.cmp_op),
        .cmp_result (cmp_result)
    );

    // Jumps always taken, conditionals follow the compare
    always_comb begin
        case (uop.branch_type)
            BRANCH_COND:             branch_taken = cmp_result;
            BRANCH_JAL, BRANCH_JALR: branch_taken = 1'b1;
            default:                 branch_taken = 1'b0;
        endcase
        // JALR is register relative, the rest PC relative
        if (uop.branch_type == BRANCH_JALR) begin
            branch_target = rs1_val + uop.immediate;
        end else begin
            branch_target = uop.pc + uop.immediate;
        end
    end

    // CSR read-modify value
    assign csr_operand = (uop.csr_src == CSR_SRC_ZIMM) ? word_t'(uop.csr_zimm) : rs1_val;

    always_comb begin
        case (uop.csr_op)
            CSR_SET:   csr_new_val = uop.csr_old_val | csr_operand;
            CSR_CLEAR: csr_new_val = uop.csr_old_val & ~csr_operand;
            default:   csr_new_val = csr_operand;
        endcase
    end

    // Hazard controls mask the outgoing valid
    assign ex_valid = uop_valid && !stall && !flush;

    always_comb begin
        ex_result.pc            = uop.pc;
        ex_result.rd_idx        = uop.rd_idx;
        ex_result.rd_we         = uop.rd_we;
        ex_result.rd_src        = uop.rd_src;
        ex_result.alu_result    = alu_result;
        ex_result.csr_old_val   = uop.csr_old_val;
        ex_result.csr_new_val   = csr_new_val;
        ex_result.branch_taken  = branch_taken;
        ex_result.branch_target = branch_target;
    end

endmodule

// File: src/branch_compare.sv
//////////////////////////////////////////////////
// Branch condition evaluation
// Signed or unsigned compare of rs1 against rs2
//////////////////////////////////////////////////

`timescale 1ns/1ps

module branch_compare
    import exec_pkg::*;
(
    input  word_t   lhs,
    input  word_t   rhs,
    input  cmp_op_e cmp_op,
    output logic    cmp_result
);

    always_comb begin
        case (cmp_op)
            CMP_EQ:  cmp_result = (lhs == rhs);
            CMP_NE:  cmp_result = (lhs != rhs);
            // Signed forms for BLT and BGE
            CMP_LT:  cmp_result = ($signed(lhs) < $signed(rhs));
            CMP_GE:  cmp_result = ($signed(lhs) >= $signed(rhs));
            CMP_LTU: cmp_result = (lhs < rhs);
            CMP_GEU: cmp_result = (lhs >= rhs);
            default: cmp_result = 1'b0;
        endcase
    end

endmodule

// File: src/exec_alu.sv
//////////////////////////////////////////////////
// Combinational RV32I integer ALU
// Used by execute for arithmetic, address and
// link value computation
//////////////////////////////////////////////////

`timescale 1ns/1ps

module exec_alu
    import exec_pkg::*;
(
    input  word_t   operand_a,
    input  word_t   operand_b,
    input  alu_op_e alu_op,
    output word_t   alu_result
);

    // Shift amount from the low 5 bits only
    logic [4:0] shamt;

    assign shamt = operand_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = operand_a + operand_b;
            ALU_SUB:  alu_result = operand_a - operand_b;
            ALU_SLL:  alu_result = operand_a << shamt;
            // Set-less-than gives 0 or 1
            ALU_SLT:  alu_result = word_t'($signed(operand_a) < $signed(operand_b));
            ALU_SLTU: alu_result = word_t'(operand_a < operand_b);
            ALU_XOR:  alu_result = operand_a ^ operand_b;
            ALU_SRL:  alu_result = operand_a >> shamt;
            // Arithmetic shift keeps the sign bit
            ALU_SRA:  alu_result = word_t'($signed(operand_a) >>> shamt);
            ALU_OR:   alu_result = operand_a | operand_b;
            ALU_AND:  alu_result = operand_a & operand_b;
            // Unused encodings
            default:  alu_result = '0;
        endcase
    end

endmodule

// File: src/forward_if.sv
//////////////////////////////////////////////////
// Bypass request and response for one operand
// Execute asks through the stage modport, the
// forwarding logic answers in the same cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface forward_if
    import exec_pkg::*;
();

    // Request from the consuming stage
    logic     stage_uses_reg;
    reg_idx_t reg_idx;

    // Response from the bypass network
    logic     use_fwd;
    word_t    fwd_val;

    modport stage (output stage_uses_reg, output reg_idx, input use_fwd, input fwd_val);
    modport fwd (input stage_uses_reg, input reg_idx, output use_fwd, output fwd_val);

endinterface

// File: src/exec_pkg.sv
//////////////////////////////////////////////////
// Types shared by the execute RTL and its bench
// Micro-op and result structs, plus the decoded
// control encodings used in both stages
//////////////////////////////////////////////////

`include "exec_params.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0]      word_t;
    typedef logic [`EXEC_REG_IDX_W-1:0] reg_idx_t;

    // ALU operations, RV32I integer subset
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // ALU operand selects
    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_CSR, OP1_ZERO} op1_src_e;
    typedef enum logic [1:0] {OP2_RS1, OP2_RS2, OP2_IMM, OP2_FOUR} op2_src_e;

    // Branch compare and branch kind
    typedef enum logic [2:0] {
        CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
    } cmp_op_e;
    typedef enum logic [1:0] {BRANCH_NONE, BRANCH_COND, BRANCH_JAL, BRANCH_JALR} branch_e;

    // CSR operand source and modification
    typedef enum logic {CSR_SRC_RS1, CSR_SRC_ZIMM} csr_src_e;
    typedef enum logic [1:0] {CSR_PASS, CSR_SET, CSR_CLEAR} csr_op_e;

    // Writeback value source
    typedef enum logic {RD_SRC_ALU, RD_SRC_CSR} rd_src_e;

    // Decoded micro-op entering execute
    typedef struct packed {
        word_t      pc;
        reg_idx_t   rs1_idx;
        reg_idx_t   rs2_idx;
        word_t      rs1_val;
        word_t      rs2_val;
        word_t      immediate;
        reg_idx_t   rd_idx;
        logic       rd_we;
        rd_src_e    rd_src;
        alu_op_e    alu_op;
        op1_src_e   op1_src;
        op2_src_e   op2_src;
        cmp_op_e    cmp_op;
        branch_e    branch_type;
        csr_src_e   csr_src;
        csr_op_e    csr_op;
        logic [4:0] csr_zimm;
        word_t      csr_old_val;
    } uop_s;

    // Execute result handed to retire
    typedef struct packed {
        word_t      pc;
        reg_idx_t   rd_idx;
        logic       rd_we;
        rd_src_e    rd_src;
        word_t      alu_result;
        word_t      csr_old_val;
        word_t      csr_new_val;
        logic       branch_taken;
        word_t      branch_target;
    } result_s;

endpackage

// File: src/exec_params.svh
//////////////////////////////////////////////////
// Width constants for the execute block
// Pulled in by the shared package, which builds
// the word and register index types from them
//////////////////////////////////////////////////

`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// One RV32I data word
`define EXEC_XLEN 32

// Index into the 32 architectural registers
`define EXEC_REG_IDX_W 5

`endif
